//--- mipsIsaPkg.sv
/*
 * Instruction-set definitions for the MIPS-like core.
 * Word and register index types, opcodes, funct codes and field positions.
 * Compiled before every module that decodes or carries instruction words.
 */
package mipsIsaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;

    // Primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ = 6'h02;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // Funct codes under opSpecial
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    // Field positions
    localparam int opLsb = 26;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;
    localparam int immWidth = 16;
    localparam int targetWidth = 26;

    localparam wordT nopWord = 32'h0000_0000;

endpackage

//--- pipeCtrlPkg.sv
/*
 * Pipeline-control definitions shared by decode, execute and the hazard unit.
 * ALU operations, destination kinds and the Tnew/Tuse timing constants.
 */
package pipeCtrlPkg;

    typedef enum logic [2:0] {
        addOp,
        subOp,
        andOp,
        orOp,
        sltOp,
        luiOp
    } aluOpT;

    // Which instruction field names the destination register
    typedef enum logic [1:0] {
        destNone,
        destRt,
        destRd
    } destKindT;

    // Cycles until a result is ready (Tnew) or an operand is needed (Tuse)
    typedef logic [1:0] stageTimeT;

    localparam stageTimeT tnewNone = 2'd0;
    localparam stageTimeT tnewAlu = 2'd1;
    localparam stageTimeT tnewLoad = 2'd2;

    localparam stageTimeT tuseBranch = 2'd0;
    localparam stageTimeT tuseAlu = 2'd1;

endpackage

//--- fetchStage.sv
/*
 * Fetch stage with the program counter and the fetch/decode register.
 * The next PC comes from PC+4 or from decode's branch and jump targets.
 * A stall from the hazard unit holds both the PC and the register.
 */
`timescale 1ns/100ps

module fetchStage #(
    parameter mipsIsaPkg::wordT resetPc = 32'h0000_3000
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic branchTaken,
    input  logic jumpTaken,
    input  mipsIsaPkg::wordT branchTarget,
    input  mipsIsaPkg::wordT jumpTarget,
    input  mipsIsaPkg::wordT instr,
    output mipsIsaPkg::wordT instrAddr,
    output mipsIsaPkg::wordT idInstr,
    output mipsIsaPkg::wordT idPc
);
    import mipsIsaPkg::*;

    wordT pc;
    wordT nextPc;

    // Branch and jump targets come from the instruction one ahead in decode
    always_comb begin
        if (branchTaken) begin
            nextPc = branchTarget;
        end else if (jumpTaken) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
            idInstr <= nopWord;
        end else if (!stall) begin
            pc <= nextPc;
            idInstr <= instr;
        end
        if (!stall) begin
            idPc <= pc;
        end
    end

    assign instrAddr = pc;

endmodule

//--- decodeStage.sv
/*
 * Decode stage with the instruction decoder and the decode/execute register.
 * Branches and jumps resolve here on forwarded operands.
 * Source indices and Tuse values go to the hazard unit; bubble loads a no-op.
 */
`timescale 1ns/100ps

module decodeStage (
    input  logic clk,
    input  logic reset,
    input  logic bubble,
    input  mipsIsaPkg::wordT idInstr,
    input  mipsIsaPkg::wordT idPc,
    output mipsIsaPkg::regAddrT readAddrA,
    output mipsIsaPkg::regAddrT readAddrB,
    input  mipsIsaPkg::wordT readDataA,
    input  mipsIsaPkg::wordT readDataB,
    input  mipsIsaPkg::regAddrT exDest,
    input  mipsIsaPkg::wordT exResult,
    input  mipsIsaPkg::regAddrT memDest,
    input  mipsIsaPkg::wordT memResult,
    output mipsIsaPkg::regAddrT srcA,
    output mipsIsaPkg::regAddrT srcB,
    output pipeCtrlPkg::stageTimeT tuseA,
    output pipeCtrlPkg::stageTimeT tuseB,
    output logic branchTaken,
    output logic jumpTaken,
    output mipsIsaPkg::wordT branchTarget,
    output mipsIsaPkg::wordT jumpTarget,
    output pipeCtrlPkg::aluOpT exAluOp,
    output mipsIsaPkg::wordT exOperandA,
    output mipsIsaPkg::wordT exOperandB,
    output mipsIsaPkg::wordT exStoreData,
    output logic exUseImm,
    output mipsIsaPkg::wordT exImm,
    output logic exIsLoad,
    output logic exIsStore,
    output mipsIsaPkg::wordT exPc,
    output mipsIsaPkg::regAddrT exSrcA,
    output mipsIsaPkg::regAddrT exSrcB,
    output mipsIsaPkg::regAddrT exDestOut,
    output pipeCtrlPkg::stageTimeT exTnew
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddrT rs;
    regAddrT rt;
    regAddrT rd;
    regAddrT dest;
    logic [immWidth-1:0] imm16;
    wordT imm;
    wordT fwdA;
    wordT fwdB;
    wordT pcPlus4;
    destKindT destKind;
    aluOpT aluOp;
    stageTimeT tnew;
    logic useImm;
    logic immZero;
    logic isLoad;
    logic isStore;
    logic isBeq;
    logic isBne;

    // Newest producer wins; the register file bypass covers writeback
    function automatic wordT forward(regAddrT addr, wordT regData);
        if (addr != '0 && addr == exDest) begin
            return exResult;
        end else if (addr != '0 && addr == memDest) begin
            return memResult;
        end
        return regData;
    endfunction

    assign opcode = idInstr[opLsb +: 6];
    assign funct = idInstr[5:0];
    assign rs = idInstr[rsLsb +: 5];
    assign rt = idInstr[rtLsb +: 5];
    assign rd = idInstr[rdLsb +: 5];
    assign imm16 = idInstr[immWidth-1:0];

    always_comb begin
        destKind = destNone;
        aluOp = addOp;
        tnew = tnewNone;
        useImm = 1'b0;
        immZero = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        isBeq = 1'b0;
        isBne = 1'b0;
        jumpTaken = 1'b0;
        srcA = '0;
        srcB = '0;
        tuseA = tuseAlu;
        tuseB = tuseAlu;
        case (opcode)
            opSpecial: begin
                destKind = destRd;
                srcA = rs;
                srcB = rt;
                tnew = tnewAlu;
                case (funct)
                    fnAddu: aluOp = addOp;
                    fnSubu: aluOp = subOp;
                    fnAnd: aluOp = andOp;
                    fnOr: aluOp = orOp;
                    fnSlt: aluOp = sltOp;
                    default: begin
                        destKind = destNone;
                        srcA = '0;
                        srcB = '0;
                        tnew = tnewNone;
                    end
                endcase
            end
            opOri: begin
                destKind = destRt;
                aluOp = orOp;
                useImm = 1'b1;
                immZero = 1'b1;
                srcA = rs;
                tnew = tnewAlu;
            end
            opLui: begin
                // Result is ready in execute already
                destKind = destRt;
                aluOp = luiOp;
                useImm = 1'b1;
                immZero = 1'b1;
            end
            opLw: begin
                destKind = destRt;
                useImm = 1'b1;
                isLoad = 1'b1;
                srcA = rs;
                tnew = tnewLoad;
            end
            opSw: begin
                useImm = 1'b1;
                isStore = 1'b1;
                srcA = rs;
                srcB = rt;
            end
            opBeq, opBne: begin
                isBeq = (opcode == opBeq);
                isBne = (opcode == opBne);
                srcA = rs;
                srcB = rt;
                tuseA = tuseBranch;
                tuseB = tuseBranch;
            end
            opJ: jumpTaken = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (destKind)
            destRt: dest = rt;
            destRd: dest = rd;
            default: dest = '0;
        endcase
    end

    assign readAddrA = rs;
    assign readAddrB = rt;
    assign fwdA = forward(rs, readDataA);
    assign fwdB = forward(rt, readDataB);
    assign imm = immZero ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    // Targets are relative to the delay slot
    assign pcPlus4 = idPc + 32'd4;
    assign branchTaken = (isBeq && fwdA == fwdB) || (isBne && fwdA != fwdB);
    assign branchTarget = pcPlus4 + {imm[29:0], 2'b00};
    assign jumpTarget = {pcPlus4[31:28], idInstr[targetWidth-1:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            exAluOp <= addOp;
            exIsLoad <= 1'b0;
            exIsStore <= 1'b0;
            exDestOut <= '0;
            exTnew <= tnewNone;
        end else begin
            exAluOp <= aluOp;
            exIsLoad <= isLoad;
            exIsStore <= isStore;
            exDestOut <= dest;
            exTnew <= tnew;
        end
        exOperandA <= fwdA;
        exOperandB <= fwdB;
        exStoreData <= fwdB;
        exUseImm <= useImm;
        exImm <= imm;
        exPc <= idPc;
        exSrcA <= srcA;
        exSrcB <= srcB;
    end

endmodule

//--- regFile.sv
/*
 * General-purpose register file with two read ports and one write port.
 * Register 0 always reads zero; a same-cycle write is bypassed to the reads.
 */
`timescale 1ns/100ps

module regFile (
    input  logic clk,
    input  logic reset,
    input  mipsIsaPkg::regAddrT readAddrA,
    input  mipsIsaPkg::regAddrT readAddrB,
    output mipsIsaPkg::wordT readDataA,
    output mipsIsaPkg::wordT readDataB,
    input  logic writeEnable,
    input  mipsIsaPkg::regAddrT writeAddr,
    input  mipsIsaPkg::wordT writeData
);
    import mipsIsaPkg::*;

    wordT regs [1:31];

    function automatic wordT readPort(regAddrT addr);
        if (addr == '0) begin
            return '0;
        end else if (writeEnable && writeAddr == addr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = readPort(readAddrA);
    assign readDataB = readPort(readAddrB);

endmodule

//--- executeStage.sv
/*
 * Execute stage with the ALU and the execute/memory register.
 * Operands from decode are forwarded again from memory and writeback.
 * Tnew counts down by one on the way into the memory stage.
 */
`timescale 1ns/100ps

module executeStage (
    input  logic clk,
    input  logic reset,
    input  pipeCtrlPkg::aluOpT exAluOp,
    input  mipsIsaPkg::wordT exOperandA,
    input  mipsIsaPkg::wordT exOperandB,
    input  mipsIsaPkg::wordT exStoreData,
    input  logic exUseImm,
    input  mipsIsaPkg::wordT exImm,
    input  logic exIsLoad,
    input  logic exIsStore,
    input  mipsIsaPkg::wordT exPc,
    input  mipsIsaPkg::regAddrT exSrcA,
    input  mipsIsaPkg::regAddrT exSrcB,
    input  mipsIsaPkg::regAddrT exDestOut,
    input  pipeCtrlPkg::stageTimeT exTnew,
    input  mipsIsaPkg::regAddrT memDest,
    input  mipsIsaPkg::wordT memResult,
    input  mipsIsaPkg::regAddrT wbDest,
    input  mipsIsaPkg::wordT wbResult,
    output mipsIsaPkg::regAddrT exDest,
    output mipsIsaPkg::wordT exResult,
    output mipsIsaPkg::wordT memAluOut,
    output mipsIsaPkg::wordT memStoreData,
    output mipsIsaPkg::wordT memPc,
    output logic memIsLoad,
    output logic memIsStore,
    output mipsIsaPkg::regAddrT memDestOut,
    output pipeCtrlPkg::stageTimeT memTnew
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    wordT opA;
    wordT opB;
    wordT storeData;
    wordT aluResult;

    function automatic wordT forward(regAddrT addr, wordT value);
        if (addr != '0 && addr == memDest) begin
            return memResult;
        end else if (addr != '0 && addr == wbDest) begin
            return wbResult;
        end
        return value;
    endfunction

    assign opA = forward(exSrcA, exOperandA);
    assign opB = exUseImm ? exImm : forward(exSrcB, exOperandB);
    assign storeData = forward(exSrcB, exStoreData);

    always_comb begin
        case (exAluOp)
            subOp: aluResult = opA - opB;
            andOp: aluResult = opA & opB;
            orOp: aluResult = opA | opB;
            sltOp: aluResult = {31'b0, $signed(opA) < $signed(opB)};
            luiOp: aluResult = {opB[15:0], 16'h0000};
            default: aluResult = opA + opB;
        endcase
    end

    // Only meaningful to decode while exTnew is zero
    assign exDest = exDestOut;
    assign exResult = aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            memIsLoad <= 1'b0;
            memIsStore <= 1'b0;
            memDestOut <= '0;
            memTnew <= tnewNone;
        end else begin
            memIsLoad <= exIsLoad;
            memIsStore <= exIsStore;
            memDestOut <= exDestOut;
            memTnew <= (exTnew == tnewNone) ? tnewNone : exTnew - 2'd1;
        end
        memAluOut <= aluResult;
        memStoreData <= storeData;
        memPc <= exPc;
    end

endmodule

//--- memoryStage.sv
/*
 * Memory stage driving the data bus, plus the memory/writeback register.
 * Loads sample busRData in their memory cycle; writeback feeds the register file.
 */
`timescale 1ns/100ps

module memoryStage (
    input  logic clk,
    input  logic reset,
    input  mipsIsaPkg::wordT memAluOut,
    input  mipsIsaPkg::wordT memStoreData,
    input  mipsIsaPkg::wordT memPc,
    input  logic memIsLoad,
    input  logic memIsStore,
    input  mipsIsaPkg::regAddrT memDestOut,
    output mipsIsaPkg::wordT busPc,
    output mipsIsaPkg::wordT busAddr,
    output mipsIsaPkg::wordT busWData,
    output logic [3:0] busWe,
    input  mipsIsaPkg::wordT busRData,
    output mipsIsaPkg::regAddrT memDest,
    output mipsIsaPkg::wordT memResult,
    output mipsIsaPkg::regAddrT wbDest,
    output mipsIsaPkg::wordT wbResult,
    output logic writeEnable,
    output mipsIsaPkg::regAddrT writeAddr,
    output mipsIsaPkg::wordT writeData
);
    // Word accesses only, so a store enables every lane
    assign busPc = memPc;
    assign busAddr = memAluOut;
    assign busWData = memStoreData;
    assign busWe = memIsStore ? 4'hf : 4'h0;

    assign memDest = memDestOut;
    assign memResult = memAluOut;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbDest <= '0;
        end else begin
            wbDest <= memDestOut;
        end
        wbResult <= memIsLoad ? busRData : memAluOut;
    end

    assign writeEnable = (wbDest != '0);
    assign writeAddr = wbDest;
    assign writeData = wbResult;

endmodule

//--- hazardUnit.sv
/*
 * Stall decision from the Tnew/Tuse comparison of decode's sources.
 * A stall holds fetch and decode and sends a bubble into execute.
 */
`timescale 1ns/100ps

module hazardUnit (
    input  mipsIsaPkg::regAddrT srcA,
    input  mipsIsaPkg::regAddrT srcB,
    input  pipeCtrlPkg::stageTimeT tuseA,
    input  pipeCtrlPkg::stageTimeT tuseB,
    input  mipsIsaPkg::regAddrT exDest,
    input  pipeCtrlPkg::stageTimeT exTnew,
    input  mipsIsaPkg::regAddrT memDest,
    input  pipeCtrlPkg::stageTimeT memTnew,
    output logic stall,
    output logic bubble
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    logic stallA;
    logic stallB;

    // Result not ready by the time this source needs it
    function automatic logic late(regAddrT src, stageTimeT tuse);
        logic exLate;
        logic memLate;
        exLate = (src == exDest) && (exTnew > tuse);
        memLate = (src == memDest) && (memTnew > tuse);
        return (src != '0) && (exLate || memLate);
    endfunction

    assign stallA = late(srcA, tuseA);
    assign stallB = late(srcB, tuseB);

    assign stall = stallA || stallB;
    assign bubble = stallA || stallB;

endmodule

//--- mipsCore.sv
/*
 * Top level of the five-stage pipelined core.
 * Instructions arrive on instrAddr/instr; data moves on the word bus.
 * Set resetPc to the address of the first instruction.
 */
`timescale 1ns/100ps

module mipsCore #(
    parameter mipsIsaPkg::wordT resetPc = 32'h0000_3000
) (
    input  logic clk,
    input  logic reset,
    output mipsIsaPkg::wordT instrAddr,
    input  mipsIsaPkg::wordT instr,
    output mipsIsaPkg::wordT busPc,
    output mipsIsaPkg::wordT busAddr,
    output mipsIsaPkg::wordT busWData,
    output logic [3:0] busWe,
    input  mipsIsaPkg::wordT busRData
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    // Fetch and decode
    logic stall;
    logic bubble;
    logic branchTaken;
    logic jumpTaken;
    wordT branchTarget;
    wordT jumpTarget;
    wordT idInstr;
    wordT idPc;
    regAddrT readAddrA;
    regAddrT readAddrB;
    wordT readDataA;
    wordT readDataB;
    regAddrT srcA;
    regAddrT srcB;
    stageTimeT tuseA;
    stageTimeT tuseB;

    // Execute
    aluOpT exAluOp;
    wordT exOperandA;
    wordT exOperandB;
    wordT exStoreData;
    wordT exImm;
    wordT exPc;
    wordT exResult;
    logic exUseImm;
    logic exIsLoad;
    logic exIsStore;
    regAddrT exSrcA;
    regAddrT exSrcB;
    regAddrT exDestOut;
    regAddrT exDest;
    stageTimeT exTnew;

    // Memory and writeback
    wordT memAluOut;
    wordT memStoreData;
    wordT memPc;
    wordT memResult;
    logic memIsLoad;
    logic memIsStore;
    regAddrT memDestOut;
    regAddrT memDest;
    stageTimeT memTnew;
    regAddrT wbDest;
    wordT wbResult;
    logic writeEnable;
    regAddrT writeAddr;
    wordT writeData;

    fetchStage #(.resetPc(resetPc)) fetchStage_i (
        .clk(clk), .reset(reset), .stall(stall),
        .branchTaken(branchTaken), .jumpTaken(jumpTaken),
        .branchTarget(branchTarget), .jumpTarget(jumpTarget),
        .instr(instr), .instrAddr(instrAddr), .idInstr(idInstr), .idPc(idPc)
    );

    decodeStage decodeStage_i (
        .clk(clk), .reset(reset), .bubble(bubble), .idInstr(idInstr), .idPc(idPc),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .readDataA(readDataA), .readDataB(readDataB),
        .exDest(exDest), .exResult(exResult), .memDest(memDest), .memResult(memResult),
        .srcA(srcA), .srcB(srcB), .tuseA(tuseA), .tuseB(tuseB),
        .branchTaken(branchTaken), .jumpTaken(jumpTaken),
        .branchTarget(branchTarget), .jumpTarget(jumpTarget),
        .exAluOp(exAluOp), .exOperandA(exOperandA), .exOperandB(exOperandB),
        .exStoreData(exStoreData), .exUseImm(exUseImm), .exImm(exImm),
        .exIsLoad(exIsLoad), .exIsStore(exIsStore), .exPc(exPc),
        .exSrcA(exSrcA), .exSrcB(exSrcB), .exDestOut(exDestOut), .exTnew(exTnew)
    );

    regFile regFile_i (
        .clk(clk), .reset(reset),
        .readAddrA(readAddrA), .readAddrB(readAddrB),
        .readDataA(readDataA), .readDataB(readDataB),
        .writeEnable(writeEnable), .writeAddr(writeAddr), .writeData(writeData)
    );

    executeStage executeStage_i (
        .clk(clk), .reset(reset),
        .exAluOp(exAluOp), .exOperandA(exOperandA), .exOperandB(exOperandB),
        .exStoreData(exStoreData), .exUseImm(exUseImm), .exImm(exImm),
        .exIsLoad(exIsLoad), .exIsStore(exIsStore), .exPc(exPc),
        .exSrcA(exSrcA), .exSrcB(exSrcB), .exDestOut(exDestOut), .exTnew(exTnew),
        .memDest(memDest), .memResult(memResult), .wbDest(wbDest), .wbResult(wbResult),
        .exDest(exDest), .exResult(exResult),
        .memAluOut(memAluOut), .memStoreData(memStoreData), .memPc(memPc),
        .memIsLoad(memIsLoad), .memIsStore(memIsStore),
        .memDestOut(memDestOut), .memTnew(memTnew)
    );

    memoryStage memoryStage_i (
        .clk(clk), .reset(reset),
        .memAluOut(memAluOut), .memStoreData(memStoreData), .memPc(memPc),
        .memIsLoad(memIsLoad), .memIsStore(memIsStore), .memDestOut(memDestOut),
        .busPc(busPc), .busAddr(busAddr), .busWData(busWData), .busWe(busWe),
        .busRData(busRData), .memDest(memDest), .memResult(memResult),
        .wbDest(wbDest), .wbResult(wbResult),
        .writeEnable(writeEnable), .writeAddr(writeAddr), .writeData(writeData)
    );

    hazardUnit hazardUnit_i (
        .srcA(srcA), .srcB(srcB), .tuseA(tuseA), .tuseB(tuseB),
        .exDest(exDest), .exTnew(exTnew), .memDest(memDest), .memTnew(memTnew),
        .stall(stall), .bubble(bubble)
    );

endmodule

//--- tbMipsCore.sv
/*
 * Directed testbench for the pipelined core.
 * Each test loads a program image, resets the core and compares the stores seen
 * on the data bus against values worked out from the instruction semantics.
 */
`timescale 1ns/100ps

module tbMipsCore;
    import mipsIsaPkg::*;

    localparam wordT resetPc = 32'h0000_3000;
    localparam int testCount = 6;
    localparam int cyclesPerTest = 300;
    localparam int clkPeriod = 8;
    localparam int storeWaitCycles = 200;

    logic clk;
    logic reset;
    wordT instrAddr;
    wordT instr;
    wordT busPc;
    wordT busAddr;
    wordT busWData;
    logic [3:0] busWe;
    wordT busRData;

    wordT imem [0:255];
    wordT dmem [0:255];
    int progLen;
    logic [31:0] rngState;
    int errorCount;
    int checkCount;
    int testsRun;

    // Expected and observed bus writes
    wordT expAddr [$];
    wordT expData [$];
    wordT expPc [$];
    wordT gotAddr [$];
    wordT gotData [$];
    wordT gotPc [$];
    logic [3:0] gotWe [$];

    mipsCore #(.resetPc(resetPc)) mipsCore_i (
        .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
        .busPc(busPc), .busAddr(busAddr), .busWData(busWData),
        .busWe(busWe), .busRData(busRData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    assign instr = imem[instrAddr[9:2]];
    assign busRData = dmem[busAddr[9:2]];

    // Bus writes sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && busWe != 4'h0) begin
            gotAddr.push_back(busAddr);
            gotData.push_back(busWData);
            gotPc.push_back(busPc);
            gotWe.push_back(busWe);
            dmem[busAddr[9:2]] = busWData;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] randomWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic wordT rType(logic [5:0] fn, regAddrT rd, regAddrT rs, regAddrT rt);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT iType(logic [5:0] op, regAddrT rt, regAddrT rs,
                                   logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT pcOf(int idx);
        return resetPc + 32'(idx * 4);
    endfunction

    task automatic emit(wordT word);
        imem[progLen[7:0]] = word;
        progLen++;
    endtask

    task automatic loadConst(regAddrT rd, wordT value);
        emit(iType(opLui, rd, 5'd0, value[31:16]));
        emit(iType(opOri, rd, rd, value[15:0]));
    endtask

    task automatic storeWord(regAddrT rt, regAddrT base, logic [15:0] offset,
                             wordT addr, wordT data);
        expAddr.push_back(addr);
        expData.push_back(data);
        expPc.push_back(pcOf(progLen));
        emit(iType(opSw, rt, base, offset));
    endtask

    // Self jump with a no-op delay slot
    task automatic endProgram();
        wordT here;
        here = pcOf(progLen);
        emit({opJ, here[27:2]});
        emit(nopWord);
    endtask

    task automatic newProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = nopWord;
            dmem[i] = 32'hdead_0000 | 32'(i * 4);
        end
        progLen = 0;
        expAddr.delete();
        expData.delete();
        expPc.delete();
    endtask

    task automatic checkWord(string what, wordT got, wordT exp);
        checkCount++;
        if (got !== exp) begin
            $display("** Error [%0t] %s: got %h, expected %h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkStore(wordT addr, wordT data, wordT pc, int idx);
        if (idx >= gotAddr.size()) begin
            $display("Store %0d to address %h never appeared on the bus", idx, addr);
            errorCount++;
        end else begin
            checkWord($sformatf("store %0d address", idx), gotAddr[idx], addr);
            checkWord($sformatf("store %0d data", idx), gotData[idx], data);
            checkWord($sformatf("store %0d pc", idx), gotPc[idx], pc);
            checkWord($sformatf("store %0d byte enables", idx), {28'h0, gotWe[idx]},
                      32'h0000_000f);
        end
    endtask

    // Reset, run until the expected stores are seen, then compare
    task automatic runProgram(string name);
        int startErrors;
        int cycles;
        startErrors = errorCount;
        @(negedge clk);
        reset = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        gotAddr.delete();
        gotData.delete();
        gotPc.delete();
        gotWe.delete();
        checkWord("instrAddr after reset", instrAddr, resetPc);
        checkWord("busWe after reset", {28'h0, busWe}, 32'h0);
        cycles = 0;
        while (gotAddr.size() < expAddr.size() && cycles < storeWaitCycles) begin
            @(negedge clk);
            cycles++;
        end
        repeat (20) @(negedge clk);
        if (gotAddr.size() > expAddr.size()) begin
            $display("%s: %0d bus writes seen where %0d were expected", name,
                     gotAddr.size(), expAddr.size());
            errorCount++;
        end
        for (int i = 0; i < expAddr.size(); i++) begin
            checkStore(expAddr[i], expData[i], expPc[i], i);
        end
        testsRun++;
        if (errorCount == startErrors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - startErrors);
        end
    endtask

    task automatic firstStoreAfterReset();
        wordT value;
        newProgram();
        value = randomWord();
        loadConst(5'd1, value);
        emit(nopWord);
        emit(nopWord);
        storeWord(5'd1, 5'd0, 16'h0010, 32'h10, value);
        endProgram();
        runProgram("reset state");
    endtask

    task automatic aluChains();
        wordT a;
        wordT b;
        wordT sum;
        wordT diff;
        wordT andVal;
        wordT orVal;
        wordT sltVal;
        newProgram();
        a = randomWord();
        b = randomWord();
        sum = a + b;
        diff = sum - a;
        andVal = diff & sum;
        orVal = andVal | a;
        sltVal = ($signed(orVal) < $signed(b)) ? 32'd1 : 32'd0;
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        emit(rType(fnAddu, 5'd3, 5'd1, 5'd2));
        emit(rType(fnSubu, 5'd4, 5'd3, 5'd1));
        emit(rType(fnAnd, 5'd5, 5'd4, 5'd3));
        emit(rType(fnOr, 5'd6, 5'd5, 5'd1));
        emit(rType(fnSlt, 5'd7, 5'd6, 5'd2));
        storeWord(5'd7, 5'd0, 16'h0020, 32'h20, sltVal);
        storeWord(5'd6, 5'd0, 16'h0024, 32'h24, orVal);
        storeWord(5'd5, 5'd0, 16'h0028, 32'h28, andVal);
        storeWord(5'd4, 5'd0, 16'h002c, 32'h2c, diff);
        storeWord(5'd3, 5'd0, 16'h0030, 32'h30, sum);
        endProgram();
        runProgram("alu chains");
    endtask

    task automatic loadUse();
        wordT x;
        wordT y;
        newProgram();
        x = randomWord();
        y = randomWord();
        dmem[16] = x;
        dmem[17] = y;
        emit(iType(opLw, 5'd1, 5'd0, 16'h0040));
        emit(iType(opLw, 5'd2, 5'd0, 16'h0044));
        emit(rType(fnAddu, 5'd3, 5'd1, 5'd2));
        storeWord(5'd3, 5'd0, 16'h0080, 32'h80, x + y);
        emit(iType(opLw, 5'd4, 5'd0, 16'h0040));
        storeWord(5'd4, 5'd0, 16'h0084, 32'h84, x);
        endProgram();
        runProgram("load-use");
    endtask

    task automatic branchesAndJumps();
        wordT jumpTo;
        newProgram();
        emit(iType(opOri, 5'd1, 5'd0, 16'd5));
        emit(iType(opOri, 5'd3, 5'd0, 16'd7));
        emit(iType(opOri, 5'd2, 5'd0, 16'd5));
        // Taken beq right after its producer
        emit(iType(opBeq, 5'd2, 5'd1, 16'd2));
        emit(iType(opOri, 5'd4, 5'd0, 16'h00a1));
        emit(iType(opOri, 5'd4, 5'd0, 16'h00ee));
        storeWord(5'd4, 5'd0, 16'h0100, 32'h100, 32'h0000_00a1);
        // Untaken bne on a load just ahead
        storeWord(5'd1, 5'd0, 16'h0104, 32'h104, 32'd5);
        emit(iType(opLw, 5'd5, 5'd0, 16'h0104));
        emit(iType(opBne, 5'd2, 5'd5, 16'd2));
        emit(iType(opOri, 5'd6, 5'd0, 16'h00b2));
        emit(iType(opOri, 5'd6, 5'd6, 16'h000c));
        storeWord(5'd6, 5'd0, 16'h0108, 32'h108, 32'h0000_00be);
        // Taken bne on an ALU result
        emit(rType(fnAddu, 5'd7, 5'd1, 5'd3));
        emit(iType(opBne, 5'd1, 5'd7, 16'd2));
        emit(iType(opOri, 5'd8, 5'd0, 16'h00c3));
        emit(iType(opOri, 5'd8, 5'd0, 16'h00dd));
        storeWord(5'd8, 5'd0, 16'h010c, 32'h10c, 32'h0000_00c3);
        // Untaken beq
        emit(iType(opBeq, 5'd3, 5'd1, 16'd2));
        emit(iType(opOri, 5'd9, 5'd0, 16'h00d4));
        emit(iType(opOri, 5'd9, 5'd9, 16'h0020));
        storeWord(5'd9, 5'd0, 16'h0110, 32'h110, 32'h0000_00f4);
        // Taken bne on a lui still in execute, then a forward jump
        emit(iType(opLui, 5'd10, 5'd0, 16'h00e5));
        emit(iType(opBne, 5'd0, 5'd10, 16'd2));
        emit(iType(opOri, 5'd11, 5'd0, 16'h00e6));
        emit(iType(opOri, 5'd11, 5'd0, 16'h00ff));
        jumpTo = pcOf(progLen + 3);
        emit({opJ, jumpTo[27:2]});
        emit(iType(opOri, 5'd11, 5'd11, 16'h0100));
        emit(iType(opOri, 5'd11, 5'd0, 16'h0bad));
        storeWord(5'd11, 5'd0, 16'h0114, 32'h114, 32'h0000_01e6);
        endProgram();
        runProgram("branches and jumps");
    endtask

    task automatic storeStream();
        wordT base;
        wordT value;
        newProgram();
        base = 32'h200 | (randomWord() & 32'h0000_00fc);
        emit(iType(opOri, 5'd1, 5'd0, base[15:0]));
        emit(iType(opOri, 5'd2, 5'd0, 16'd8));
        for (int k = 0; k < 8; k++) begin
            value = randomWord();
            loadConst(5'd3, value);
            storeWord(5'd3, 5'd1, 16'h0000, base + 32'(k * 8), value);
            emit(rType(fnAddu, 5'd1, 5'd1, 5'd2));
        end
        endProgram();
        runProgram("store stream");
    endtask

    task automatic registerZero();
        newProgram();
        emit(iType(opOri, 5'd1, 5'd0, 16'h0077));
        emit(iType(opOri, 5'd0, 5'd0, 16'h0055));
        emit(rType(fnAddu, 5'd0, 5'd1, 5'd1));
        emit(iType(opLui, 5'd0, 5'd0, 16'h1234));
        storeWord(5'd0, 5'd0, 16'h0180, 32'h180, 32'h0);
        emit(nopWord);
        emit(nopWord);
        emit(nopWord);
        storeWord(5'd0, 5'd0, 16'h0184, 32'h184, 32'h0);
        storeWord(5'd1, 5'd0, 16'h0188, 32'h188, 32'h0000_0077);
        endProgram();
        runProgram("register zero");
    endtask

    initial begin
        #(testCount * cyclesPerTest * clkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        rngState = 32'hcf16_fdc3;
        errorCount = 0;
        checkCount = 0;
        testsRun = 0;
        firstStoreAfterReset();
        aluChains();
        loadUse();
        branchesAndJumps();
        storeStream();
        registerZero();
        $display("tests %0d, checks %0d, errors %0d", testsRun, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
mipsIsaPkg.sv
pipeCtrlPkg.sv
fetchStage.sv
decodeStage.sv
regFile.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
mipsCore.sv
tbMipsCore.sv

//--- runSim.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it, and
# return a failing status unless the pass message is printed.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tbMipsCore -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && exit 0 \
    || exit 1
